// File: tb.f
+incdir+verilog
verilog/csr_index_pkg.sv
verilog/packet_fifo.sv
verilog/csr_index_configure.sv
verilog/csr_index_generator.sv
verilog/engine_csr_index.sv
tb/tb_engine_csr_index.sv

// File: Makefile
# Verilator build for the CSR index engine testbench
#   make lint   static checks of RTL and testbench
#   make sim    build and run, fails unless the pass line is printed
#   make clean  remove build output

VERILATOR  ?= verilator
TOP        ?= tb_engine_csr_index
RTL_TOP    ?= engine_csr_index
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
PASS_TEXT  ?= RESULT: PASS
VFLAGS     ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(shell grep -v '^+' $(FILELIST)) verilog/csr_index_defs.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_engine_csr_index.sv
/*
 * Directed testbench for the CSR index engine top level. Sends config
 * words on the response stream, drains read requests and compares them
 * with a reference model of the index and address rule.
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_defs.svh"

module tb_engine_csr_index;

    localparam int CLK_HALF       = 20;
    localparam int TIMEOUT_CYCLES = 300;
    localparam int IDX_LSB        = `ADDR_W;
    localparam int CMD_LSB        = `ADDR_W + `INDEX_W;
    localparam int RSVD_W         = `MEM_PAYLOAD_W - `CFG_ID_W - `CFG_VALUE_W;

    localparam logic [`CFG_ID_W-1:0] ID_NONE  = 4'd0;
    localparam logic [`CFG_ID_W-1:0] ID_BASE  = 4'd1;
    localparam logic [`CFG_ID_W-1:0] ID_FIRST = 4'd2;
    localparam logic [`CFG_ID_W-1:0] ID_COUNT = 4'd3;
    localparam logic [`CMD_W-1:0]    CMD_READ_CODE = 4'd1;

    logic                      ap_clk;
    logic                      areset_csr_engine;
    logic                      response_memory_in_valid;
    logic [`MEM_PAYLOAD_W-1:0] response_memory_in_payload;
    logic                      response_memory_in_prog_full;
    logic                      request_memory_out_rd_en;
    logic                      request_memory_out_valid;
    logic [`MEM_PAYLOAD_W-1:0] request_memory_out_payload;
    logic                      request_memory_out_empty;
    logic                      fifo_setup_signal;
    logic                      done_out;

    int                        error_count;
    int                        check_count;
    logic [31:0]               rng_state;
    logic [`MEM_PAYLOAD_W-1:0] got_q[$];

    engine_csr_index i_engine_csr_index (
        .ap_clk                      (ap_clk),
        .areset_csr_engine           (areset_csr_engine),
        .response_memory_in_valid    (response_memory_in_valid),
        .response_memory_in_payload  (response_memory_in_payload),
        .response_memory_in_prog_full(response_memory_in_prog_full),
        .request_memory_out_rd_en    (request_memory_out_rd_en),
        .request_memory_out_valid    (request_memory_out_valid),
        .request_memory_out_payload  (request_memory_out_payload),
        .request_memory_out_empty    (request_memory_out_empty),
        .fifo_setup_signal           (fifo_setup_signal),
        .done_out                    (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #CLK_HALF ap_clk = ~ap_clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Reference model: request k of a run
    function automatic logic [`MEM_PAYLOAD_W-1:0] expected_request(
        input logic [`ADDR_W-1:0] base, input logic [`INDEX_W-1:0] first, input int k);
        logic [`INDEX_W-1:0] index;
        logic [`ADDR_W-1:0]  address;
        index   = first + `INDEX_W'(k);
        address = base + `ADDR_W'(index) * `ADDR_W'(`CSR_INDEX_BYTES);
        return {CMD_READ_CODE, index, address};
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s at %0t: got 0x%0h, expected 0x%0h",
                     name, $time, actual, expected);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // All driving and sampling happens 1 ns after the rising edge
    task automatic tick();
        @(posedge ap_clk);
        #1;
    endtask

    task automatic send_word(input logic [`CFG_ID_W-1:0] id, input logic [31:0] value);
        int n;
        n = 0;
        while (response_memory_in_prog_full && n < TIMEOUT_CYCLES) begin
            tick();
            n++;
        end
        if (response_memory_in_prog_full) begin
            report_error("response input stayed programmably full");
        end
        response_memory_in_valid   = 1'b1;
        response_memory_in_payload = {id, {RSVD_W{1'b0}}, value};
        tick();
        response_memory_in_valid   = 1'b0;
    endtask

    task automatic send_config(input logic [31:0] base, input logic [`INDEX_W-1:0] first,
                               input logic [31:0] count);
        send_word(ID_BASE, base);
        send_word(ID_FIRST, {4'h0, first});
        send_word(ID_COUNT, count);
    endtask

    task automatic wait_done_fall();
        int n;
        n = 0;
        while (done_out && n < TIMEOUT_CYCLES) begin
            tick();
            n++;
        end
        if (done_out) begin
            report_error("done_out did not fall after a new configuration");
        end
    endtask

    // Pops until done_out, then a few more cycles to catch extra requests
    task automatic drain_requests();
        int n;
        got_q.delete();
        n = 0;
        request_memory_out_rd_en = 1'b1;
        while (!done_out && n < TIMEOUT_CYCLES) begin
            tick();
            n++;
            if (request_memory_out_valid) begin
                got_q.push_back(request_memory_out_payload);
            end
        end
        if (!done_out) begin
            report_error("done_out did not rise while draining requests");
        end
        request_memory_out_rd_en = 1'b0;
        repeat (4) begin
            tick();
            if (request_memory_out_valid) begin
                got_q.push_back(request_memory_out_payload);
            end
        end
    endtask

    task automatic check_run(input logic [31:0] base, input logic [`INDEX_W-1:0] first,
                             input int count);
        logic [`MEM_PAYLOAD_W-1:0] exp;
        check_value("request count", 64'(got_q.size()), 64'(count));
        for (int k = 0; k < got_q.size() && k < count; k++) begin
            exp = expected_request(base, first, k);
            check_value("cmd", 64'(got_q[k][CMD_LSB +: `CMD_W]), 64'(exp[CMD_LSB +: `CMD_W]));
            check_value("index", 64'(got_q[k][IDX_LSB +: `INDEX_W]),
                        64'(exp[IDX_LSB +: `INDEX_W]));
            check_value("address", 64'(got_q[k][`ADDR_W-1:0]), 64'(exp[`ADDR_W-1:0]));
        end
        check_value("done_out", 64'(done_out), 64'd1);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset();
        int n;
        check_value("done_out", 64'(done_out), 64'd0);
        check_value("request_memory_out_valid", 64'(request_memory_out_valid), 64'd0);
        check_value("fifo_setup_signal", 64'(fifo_setup_signal), 64'd1);
        n = 0;
        while (fifo_setup_signal && n < TIMEOUT_CYCLES) begin
            tick();
            n++;
        end
        if (fifo_setup_signal) begin
            report_error("fifo_setup_signal stayed high after reset");
        end
        // Both FIFOs idle and ready once setup is over
        check_value("response_memory_in_prog_full", 64'(response_memory_in_prog_full), 64'd0);
        check_value("request_memory_out_empty", 64'(request_memory_out_empty), 64'd1);
    endtask

    task automatic run_one(input logic [31:0] base, input logic [`INDEX_W-1:0] first,
                           input int count);
        send_config(base, first, 32'(count));
        wait_done_fall();
        drain_requests();
        check_run(base, first, count);
    endtask

    task automatic test_back_pressure();
        logic [31:0]         base;
        logic [`INDEX_W-1:0] first;
        int                  count;
        int                  n;
        int                  stray;
        base  = next_random();
        first = `INDEX_W'(next_random() & 32'h000f_ffff);
        count = `FIFO_PROG_THRESH + 1 + int'(next_random() % (20 - `FIFO_PROG_THRESH));
        send_config(base, first, 32'(count));
        wait_done_fall();
        n = 0;
        while (request_memory_out_empty && n < TIMEOUT_CYCLES) begin
            tick();
            n++;
        end
        if (request_memory_out_empty) begin
            report_error("request FIFO stayed empty with rd_en held low");
        end
        // Generator should park at prog_full with nothing delivered
        stray = 0;
        repeat (3 * count) begin
            tick();
            if (request_memory_out_valid || done_out) begin
                stray++;
            end
        end
        check_value("stray valid or done while stalled", 64'(stray), 64'd0);
        drain_requests();
        check_run(base, first, count);
    endtask

    // Id 0 word sits between the others, so decoding it as any id corrupts the run
    task automatic test_config_decode();
        send_word(ID_FIRST, 32'h0000_0040);
        send_word(ID_BASE, 32'h1111_0000);
        send_word(ID_BASE, 32'h2222_0000);
        send_word(ID_NONE, 32'hdead_beef);
        send_word(ID_COUNT, 32'd3);
        wait_done_fall();
        drain_requests();
        check_run(32'h2222_0000, `INDEX_W'(32'h40), 3);
    endtask

    task automatic test_repeated_runs();
        logic [31:0]         base;
        logic [`INDEX_W-1:0] first;
        int                  count;
        repeat (3) begin
            base  = next_random();
            first = `INDEX_W'(next_random() & 32'h000f_ffff);
            count = 1 + int'(next_random() % 20);
            run_one(base, first, count);
        end
    endtask

    initial begin
        error_count                = 0;
        check_count                = 0;
        rng_state                  = 32'h61e6_e69c;
        areset_csr_engine          = 1'b1;
        response_memory_in_valid   = 1'b0;
        response_memory_in_payload = '0;
        request_memory_out_rd_en   = 1'b0;
        repeat (8) @(posedge ap_clk);
        #1;
        areset_csr_engine = 1'b0;

        test_reset();
        run_one(32'h1000_0000, `INDEX_W'(32'h10), 5);
        test_back_pressure();
        test_config_decode();
        run_one(32'h3000_0000, `INDEX_W'(32'h7), 0);
        test_repeated_runs();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/engine_csr_index.sv
/*
 * CSR index engine top. Registers all ports, buffers memory responses
 * and outgoing read requests in FIFOs, and connects the configure block
 * to the request generator. done_out marks a fully issued, drained run.
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_defs.svh"

module engine_csr_index
    import csr_index_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_csr_engine,
    input  logic         response_memory_in_valid,
    input  mem_payload_u response_memory_in_payload,
    output logic         response_memory_in_prog_full,
    input  logic         request_memory_out_rd_en,
    output logic         request_memory_out_valid,
    output mem_payload_u request_memory_out_payload,
    output logic         request_memory_out_empty,
    output logic         fifo_setup_signal,
    output logic         done_out
);

    logic areset_fifo;

    // Port registers
    logic         response_in_valid_reg;
    mem_payload_u response_in_payload_reg;
    logic         request_out_rd_en_reg;

    // Response FIFO
    logic         rsp_fifo_rd_en;
    mem_payload_u rsp_fifo_dout;
    logic         rsp_fifo_valid;
    logic         rsp_fifo_empty;
    logic         rsp_fifo_prog_full;
    logic         rsp_fifo_reset_busy;

    // Request FIFO
    logic         req_fifo_rd_en;
    mem_payload_u req_fifo_dout;
    logic         req_fifo_valid;
    logic         req_fifo_empty;
    logic         req_fifo_prog_full;
    logic         req_fifo_reset_busy;

    // Configure to generator
    csr_index_config_t run_config;
    logic              config_valid;
    logic              gen_req_valid;
    mem_payload_u      gen_req_payload;
    logic              run_finished;

    // FIFOs see reset one cycle late, which stretches the setup window
    always_ff @(posedge ap_clk) begin
        areset_fifo <= areset_csr_engine;
    end

    // ------------------------------
    // Input registers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            response_in_valid_reg <= 1'b0;
            request_out_rd_en_reg <= 1'b0;
        end else begin
            response_in_valid_reg <= response_memory_in_valid;
            request_out_rd_en_reg <= request_memory_out_rd_en;
        end
    end

    always_ff @(posedge ap_clk) begin
        response_in_payload_reg <= response_memory_in_payload;
    end

    // ------------------------------
    // Output registers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            fifo_setup_signal            <= 1'b1;
            response_memory_in_prog_full <= 1'b1;
            request_memory_out_valid     <= 1'b0;
            request_memory_out_empty     <= 1'b1;
            done_out                     <= 1'b0;
        end else begin
            fifo_setup_signal            <= rsp_fifo_reset_busy | req_fifo_reset_busy;
            // Producer also holds off while the FIFO still refuses writes
            response_memory_in_prog_full <= rsp_fifo_prog_full | rsp_fifo_reset_busy;
            request_memory_out_valid     <= req_fifo_valid;
            request_memory_out_empty     <= req_fifo_empty;
            done_out                     <= !config_valid && run_finished && req_fifo_empty;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_memory_out_payload <= req_fifo_dout;
    end

    // ------------------------------
    // Response FIFO
    // ------------------------------
    // Configure block never stalls
    assign rsp_fifo_rd_en = !rsp_fifo_empty;

    packet_fifo #(
        .DEPTH      (`FIFO_DEPTH),
        .WIDTH      (`MEM_PAYLOAD_W),
        .PROG_THRESH(`FIFO_PROG_THRESH)
    ) i_response_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_fifo),
        .wr_en            (response_in_valid_reg),
        .din              (response_in_payload_reg),
        .rd_en            (rsp_fifo_rd_en),
        .dout             (rsp_fifo_dout),
        .valid            (rsp_fifo_valid),
        .full             (),
        .empty            (rsp_fifo_empty),
        .prog_full        (rsp_fifo_prog_full),
        .reset_busy       (rsp_fifo_reset_busy)
    );

    csr_index_configure i_csr_index_configure (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .response_valid   (rsp_fifo_valid),
        .response_payload (rsp_fifo_dout),
        .config_out       (run_config),
        .config_valid     (config_valid)
    );

    csr_index_generator i_csr_index_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .config_valid     (config_valid),
        .config_in        (run_config),
        .fifo_prog_full   (req_fifo_prog_full),
        .req_valid        (gen_req_valid),
        .req_payload      (gen_req_payload),
        .run_finished     (run_finished)
    );

    // ------------------------------
    // Request FIFO
    // ------------------------------
    assign req_fifo_rd_en = request_out_rd_en_reg && !req_fifo_empty;

    packet_fifo #(
        .DEPTH      (`FIFO_DEPTH),
        .WIDTH      (`MEM_PAYLOAD_W),
        .PROG_THRESH(`FIFO_PROG_THRESH)
    ) i_request_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_fifo),
        .wr_en            (gen_req_valid),
        .din              (gen_req_payload),
        .rd_en            (req_fifo_rd_en),
        .dout             (req_fifo_dout),
        .valid            (req_fifo_valid),
        .full             (),
        .empty            (req_fifo_empty),
        .prog_full        (req_fifo_prog_full),
        .reset_busy       (req_fifo_reset_busy)
    );

endmodule

`default_nettype wire

// File: verilog/csr_index_generator.sv
/*
 * Walks the configured CSR index range and writes one read request per
 * cycle into the request FIFO, pausing while that FIFO is programmably
 * full. run_finished holds high from the end of a run until the next start.
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_defs.svh"

module csr_index_generator
    import csr_index_pkg::*;
(
    input  logic              ap_clk,
    input  logic              areset_csr_engine,
    input  logic              config_valid,
    input  csr_index_config_t config_in,
    input  logic              fifo_prog_full,
    output logic              req_valid,
    output mem_payload_u      req_payload,
    output logic              run_finished
);

    localparam int ADDR_W = `ADDR_W;
    localparam int CNT_W  = `CFG_VALUE_W;

    localparam logic [ADDR_W-1:0] ADDR_STEP = ADDR_W'(`CSR_INDEX_BYTES);

    // Idle when low, issuing when high
    logic                running;
    logic [`INDEX_W-1:0] cur_index;
    logic [ADDR_W-1:0]   cur_addr;
    logic [CNT_W-1:0]    remaining;
    logic [ADDR_W-1:0]   start_addr;
    logic                start;

    assign start = config_valid && !running;

    assign start_addr = config_in.base_addr
                      + ({{(ADDR_W - `INDEX_W){1'b0}}, config_in.first_index} * ADDR_STEP);

    // ------------------------------
    // Request out
    // ------------------------------
    assign req_valid = running && !fifo_prog_full;

    always_comb begin
        req_payload.req.cmd     = CMD_READ;
        req_payload.req.index   = cur_index;
        req_payload.req.address = cur_addr;
    end

    // ------------------------------
    // Run control
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            running      <= 1'b0;
            run_finished <= 1'b0;
        end else if (start) begin
            // Empty range finishes at once
            running      <= (config_in.index_count != '0);
            run_finished <= (config_in.index_count == '0);
        end else if (req_valid && remaining == CNT_W'(1)) begin
            running      <= 1'b0;
            run_finished <= 1'b1;
        end
    end

    // Walk state
    always_ff @(posedge ap_clk) begin
        if (start) begin
            cur_index <= config_in.first_index;
            cur_addr  <= start_addr;
            remaining <= config_in.index_count;
        end else if (req_valid) begin
            cur_index <= cur_index + 1'b1;
            cur_addr  <= cur_addr + ADDR_STEP;
            remaining <= remaining - 1'b1;
        end
    end

    // The request FIFO relies on this to stay below full
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        !(req_valid && fifo_prog_full))
        else $error("request issued while FIFO is programmably full");

endmodule

`default_nettype wire

// File: verilog/csr_index_configure.sv
/*
 * Collects base address, first index and index count from config words
 * on the memory response stream. Words may come in any order; once all
 * three are seen, config_valid pulses for one cycle with the values.
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_defs.svh"

module csr_index_configure
    import csr_index_pkg::*;
(
    input  logic              ap_clk,
    input  logic              areset_csr_engine,
    input  logic              response_valid,
    input  mem_payload_u      response_payload,
    output csr_index_config_t config_out,
    output logic              config_valid
);

    // Bit 0 base, bit 1 first index, bit 2 count
    logic [2:0]              seen_mask;
    logic [2:0]              mask_next;
    logic [`ADDR_W-1:0]      base_q;
    logic [`ADDR_W-1:0]      base_next;
    logic [`INDEX_W-1:0]     first_q;
    logic [`INDEX_W-1:0]     first_next;
    logic [`CFG_VALUE_W-1:0] count_q;
    logic [`CFG_VALUE_W-1:0] count_next;

    // ------------------------------
    // Decode the incoming word
    // ------------------------------
    always_comb begin
        mask_next  = seen_mask;
        base_next  = base_q;
        first_next = first_q;
        count_next = count_q;
        if (response_valid) begin
            case (response_payload.cfg.cfg_id)
                CFG_BASE_ADDR: begin
                    mask_next[0] = 1'b1;
                    base_next    = response_payload.cfg.cfg_value[`ADDR_W-1:0];
                end
                CFG_FIRST_INDEX: begin
                    mask_next[1] = 1'b1;
                    first_next   = response_payload.cfg.cfg_value[`INDEX_W-1:0];
                end
                CFG_INDEX_COUNT: begin
                    mask_next[2] = 1'b1;
                    count_next   = response_payload.cfg.cfg_value;
                end
                default: begin
                end
            endcase
        end
    end

    // Seen mask and pulse
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            seen_mask    <= '0;
            config_valid <= 1'b0;
        end else if (&mask_next) begin
            seen_mask    <= '0;
            config_valid <= 1'b1;
        end else begin
            seen_mask    <= mask_next;
            config_valid <= 1'b0;
        end
    end

    // Captured values; a repeated id simply overwrites
    always_ff @(posedge ap_clk) begin
        base_q  <= base_next;
        first_q <= first_next;
        count_q <= count_next;
        if (&mask_next) begin
            config_out.base_addr   <= base_next;
            config_out.first_index <= first_next;
            config_out.index_count <= count_next;
        end
    end

    // A full set needs three words, so two pulses in a row mean lost state
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        config_valid |=> !config_valid)
        else $error("config_valid high on two consecutive cycles");

endmodule

`default_nettype wire

// File: verilog/packet_fifo.sv
/*
 * Synchronous FIFO with one-cycle read latency and a valid strobe.
 * prog_full flags occupancy at or above PROG_THRESH. After reset the
 * FIFO stays busy for a few cycles and drops writes meanwhile.
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_defs.svh"

module packet_fifo #(
    parameter int DEPTH       = `FIFO_DEPTH,
    parameter int WIDTH       = `MEM_PAYLOAD_W,
    parameter int PROG_THRESH = `FIFO_PROG_THRESH
) (
    input  logic             ap_clk,
    input  logic             areset_csr_engine,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             full,
    output logic             empty,
    output logic             prog_full,
    output logic             reset_busy
);

    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int BUSY_W = $clog2(`FIFO_RESET_BUSY_CYCLES + 1);

    logic [WIDTH-1:0]  mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [BUSY_W-1:0] busy_cnt;
    logic              do_write;
    logic              do_read;

    assign do_write = wr_en && !full && !reset_busy;
    assign do_read  = rd_en && !empty;

    assign full       = (count == CNT_W'(DEPTH));
    assign empty      = (count == '0);
    assign prog_full  = (count >= CNT_W'(PROG_THRESH));
    assign reset_busy = (busy_cnt != '0);

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            valid    <= 1'b0;
            busy_cnt <= BUSY_W'(`FIFO_RESET_BUSY_CYCLES);
        end else begin
            if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_write) - CNT_W'(do_read);
            valid <= do_read;
        end
    end

    // Storage and read port
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
        if (do_read) begin
            dout <= mem[rd_ptr];
        end
    end

    // Upstream must respect full, downstream must respect empty
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine) !(wr_en && full))
        else $error("write into a full FIFO");
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine) !(rd_en && empty))
        else $error("read from an empty FIFO");

endmodule

`default_nettype wire

// File: verilog/csr_index_pkg.sv
/*
 * Types shared by the CSR index engine: request command, configuration
 * word id, the 64-bit memory word with its request and config views,
 * and the captured run configuration.
 */
`default_nettype none

`include "csr_index_defs.svh"

package csr_index_pkg;

    typedef enum logic [`CMD_W-1:0] {
        CMD_NONE = 0,
        CMD_READ = 1
    } mem_cmd_e;

    // Id 0 carries no configuration and is dropped
    typedef enum logic [`CFG_ID_W-1:0] {
        CFG_NONE        = 0,
        CFG_BASE_ADDR   = 1,
        CFG_FIRST_INDEX = 2,
        CFG_INDEX_COUNT = 3
    } cfg_id_e;

    // ------------------------------
    // Memory word views
    // ------------------------------
    typedef struct packed {
        mem_cmd_e            cmd;
        logic [`INDEX_W-1:0] index;
        logic [`ADDR_W-1:0]  address;
    } mem_request_t;

    typedef struct packed {
        cfg_id_e                                          cfg_id;
        logic [`MEM_PAYLOAD_W-`CFG_ID_W-`CFG_VALUE_W-1:0] reserved;
        logic [`CFG_VALUE_W-1:0]                          cfg_value;
    } mem_config_t;

    // Same word, decoded as request on the way out and as config on the way in
    typedef union packed {
        mem_request_t req;
        mem_config_t  cfg;
    } mem_payload_u;

    typedef struct packed {
        logic [`ADDR_W-1:0]      base_addr;
        logic [`INDEX_W-1:0]     first_index;
        logic [`CFG_VALUE_W-1:0] index_count;
    } csr_index_config_t;

endpackage

`default_nettype wire

// File: verilog/csr_index_defs.svh
/*
 * Sizes and constants of the CSR index engine.
 * Included by the package and by every module that sizes a port,
 * a counter or an address step from these values.
 */
`ifndef CSR_INDEX_DEFS_SVH
`define CSR_INDEX_DEFS_SVH

// ------------------------------
// Memory word layout
// ------------------------------
`define MEM_PAYLOAD_W 64
`define ADDR_W 32
`define INDEX_W 28
`define CMD_W 4
`define CFG_ID_W 4
`define CFG_VALUE_W 32

// Byte distance between two CSR index entries
`define CSR_INDEX_BYTES 4

// ------------------------------
// FIFO defaults
// ------------------------------
`define FIFO_DEPTH 16
`define FIFO_PROG_THRESH 8

// Writes are refused this long after reset
`define FIFO_RESET_BUSY_CYCLES 4

`endif
